/* bench/exec_pipe_chk.sv */
`timescale 1ns/100ps

module exec_pipe_chk import alu_pkg::*; (
	input logic            clk,
	input logic            rst_n,
	input logic            wb_valid,
	input logic            wb_illegal,
	input logic [XLEN-1:0] wb_data,
	input logic            wb_zero
);

	// A slot is either a result or an illegal marker, never both
	a_pulse_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_valid && wb_illegal))
		else $error("wb_valid and wb_illegal high in the same cycle");

	// Pipeline comes out of reset empty
	a_quiet_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> (!wb_valid && !wb_illegal))
		else $error("writeback pulse in the first cycle after reset release");

	a_zero_flag: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> (wb_zero == (wb_data == '0)))
		else $error("wb_zero does not match wb_data");  // Only defined with wb_valid

endmodule

bind exec_pipe exec_pipe_chk exec_pipe_chk_inst (
	.clk, .rst_n, .wb_valid, .wb_illegal, .wb_data, .wb_zero
);

/* bench/exec_pipe_tb.sv */
`timescale 1ns/100ps

module exec_pipe_tb import alu_pkg::*, rv_isa_pkg::*; ();

	localparam int          NUM_TESTS = 42;
	localparam int          FIELDS    = 5;          // instr, rd, data, zero, illegal
	localparam logic [15:0] LFSR_SEED = 16'd52691;

	logic            clk = 1'b0;
	logic            rst_n;
	logic            instr_valid;
	logic [31:0]     instr;
	logic            wb_valid;
	logic            wb_illegal;
	reg_idx_t        wb_rd;
	logic [XLEN-1:0] wb_data;
	logic            wb_zero;

	logic [31:0]     tests_mem [0:NUM_TESTS*FIELDS-1];
	logic [15:0]     lfsr;
	int              cycle = 0;                     // Rising edges seen so far
	int              pend_idx [$];                  // Issued tests waiting for writeback
	int              pend_due [$];                  // Cycle count at which each one is due
	int              pass_cnt = 0;
	int              fail_cnt = 0;
	int              hard_errs = 0;                 // Stray pulses and timeouts
	int              cur_errs;

	exec_pipe exec_pipe_inst (
		.clk, .rst_n, .instr_valid, .instr,
		.wb_valid, .wb_illegal, .wb_rd, .wb_data, .wb_zero
	);

	always #20 clk = ~clk;                         // 40 ns period

	always @(posedge clk) cycle <= cycle + 1;

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic check_data(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
			cur_errs++;
		end
	endtask

	task automatic check_rd(input string name, input reg_idx_t exp, input reg_idx_t act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
			cur_errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
			cur_errs++;
		end
	endtask

	task automatic verify_writeback(input int idx);
		int base;
		logic e_ill;
		base     = idx * FIELDS;
		e_ill    = tests_mem[base+4][0];
		cur_errs = 0;
		if (!wb_valid && !wb_illegal) begin
			$display("test %0d: no writeback pulse at %0t where one was due", idx, $time);
			cur_errs++;
		end else begin
			check_flag("wb_illegal", e_ill, wb_illegal);
			check_flag("wb_valid", !e_ill, wb_valid);
			if (!e_ill) begin                          // Result fields only mean something here
				check_rd("wb_rd", tests_mem[base+1][4:0], wb_rd);
				check_data("wb_data", tests_mem[base+2], wb_data);
				check_flag("wb_zero", tests_mem[base+3][0], wb_zero);
			end
		end
		if (cur_errs == 0) begin
			pass_cnt++;
			$display("test %0d instr %h ok", idx, tests_mem[base]);
		end else begin
			fail_cnt++;
			$display("test %0d instr %h failed with %0d errors", idx, tests_mem[base], cur_errs);
		end
	endtask

	// Outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin
		if (pend_due.size() > 0 && pend_due[0] == cycle) begin
			verify_writeback(pend_idx.pop_front());
			void'(pend_due.pop_front());
		end else if (rst_n && (wb_valid || wb_illegal)) begin
			$display("unexpected writeback pulse at %0t with no instruction due", $time);
			hard_errs++;
		end
	end

	initial begin
		int wait_cnt;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		lfsr        = LFSR_SEED;
		$readmemh("bench/exec_pipe_tests.txt", tests_mem);
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		wait_cnt = 0;
		while (!rst_n && wait_cnt < 10) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (rst_n) begin
			for (int i = 0; i < NUM_TESTS; i++) begin
				@(posedge clk);
				if (lfsr[0]) begin                      // One bit per slot picks an idle cycle
					instr_valid <= 1'b0;
					@(posedge clk);
				end
				lfsr = lfsr_step(lfsr);
				instr_valid <= 1'b1;
				instr       <= tests_mem[i*FIELDS];
				pend_idx.push_back(i);
				pend_due.push_back(cycle + 4);          // Drive edge is cycle + 1, result three later
			end
			@(posedge clk);
			instr_valid <= 1'b0;
			wait_cnt = 0;
			while (pend_idx.size() > 0 && wait_cnt < 20) begin
				@(posedge clk);
				wait_cnt++;
			end
			if (pend_idx.size() > 0) begin
				$display("drain timed out with %0d results outstanding", pend_idx.size());
				hard_errs++;
			end
		end else begin
			$display("reset never released, no tests issued");
			hard_errs++;
		end
		$display("%0d tests: %0d passed, %0d failed, %0d other errors",
			NUM_TESTS, pass_cnt, fail_cnt, hard_errs);
		if (pass_cnt == NUM_TESTS && hard_errs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* bench/exec_pipe_tests.txt */
// instr    rd data     zero illegal   (all hex, one test per line)
00500093 01 00000005 0 0 // addi x1, x0, 5
FFD00113 02 FFFFFFFD 0 0 // addi x2, x0, -3
002081B3 03 00000002 0 0 // add  x3, x1, x2
40208233 04 00000008 0 0 // sub  x4, x1, x2
401102B3 05 FFFFFFF8 0 0 // sub  x5, x2, x1
40100333 06 FFFFFFFB 0 0 // sub  x6, x0, x1 wraps below zero
401083B3 07 00000000 1 0 // sub  x7, x1, x1
00112433 08 00000001 0 0 // slt  x8, x2, x1 signed
001134B3 09 00000000 1 0 // sltu x9, x2, x1 unsigned
0020B533 0A 00000001 0 0 // sltu x10, x1, x2
0F000593 0B 000000F0 0 0 // addi x11, x0, 0xf0
00F5F613 0C 00000000 1 0 // andi x12, x11, 0x0f disjoint masks
00F5E693 0D 000000FF 0 0 // ori  x13, x11, 0x0f
0F06C713 0E 0000000F 0 0 // xori x14, x13, 0xf0
001147B3 0F FFFFFFF8 0 0 // xor  x15, x2, x1
00B17833 10 000000F0 0 0 // and  x16, x2, x11
00B0E8B3 11 000000F5 0 0 // or   x17, x1, x11
FFE12913 12 00000001 0 0 // slti x18, x2, -2
FFF0B993 13 00000001 0 0 // sltiu x19, x1, -1
00409A13 14 00000050 0 0 // slli x20, x1, 4
01C15A93 15 0000000F 0 0 // srli x21, x2, 28
40115B13 16 FFFFFFFE 0 0 // srai x22, x2, 1
02400B93 17 00000024 0 0 // addi x23, x0, 36
01709C33 18 00000050 0 0 // sll  x24, x1, x23 uses 36 mod 32
4172DCB3 19 FFFFFFFF 0 0 // sra  x25, x5, x23
0172DD33 1A 0FFFFFFF 0 0 // srl  x26, x5, x23
00108093 01 00000006 0 0 // addi x1, x1, 1
001080B3 01 0000000C 0 0 // add  x1, x1, x1
403081B3 03 0000000A 0 0 // sub  x3, x1, x3
00308233 04 00000016 0 0 // add  x4, x1, x3
004082B3 05 00000022 0 0 // add  x5, x1, x4
00118333 06 00000016 0 0 // add  x6, x3, x1
00708013 00 00000013 0 0 // addi x0, x1, 7
000003B3 07 00000000 1 0 // add  x7, x0, x0
0000A483 00 00000000 0 1 // lw   x9 is not supported
40000513 00 00000000 0 1 // addi x10 with bit 30 set
021085B3 00 00000000 0 1 // mul  x11, x1, x1
4010F633 00 00000000 0 1 // and  x12 with bit 30 set
40109693 00 00000000 0 1 // slli x13 with bit 30 set
00A48733 0E 00000001 0 0 // add  x14, x9, x10
00C5E7B3 0F 000000F0 0 0 // or   x15, x11, x12
00068833 10 000000FF 0 0 // add  x16, x13, x0

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module exec_pipe_tb \
	-f sim.f --Mdir obj_dir -o exec_pipe_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/exec_pipe_sim > sim.log 2>&1

grep -qF '*** TEST PASSED ***' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

/* sim.f */
verilog/alu_pkg.sv
verilog/rv_isa_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/instr_decoder.sv
verilog/operand_stage.sv
verilog/execute_stage.sv
verilog/exec_pipe.sv
bench/exec_pipe_chk.sv
bench/exec_pipe_tb.sv

/* verilog/alu.sv */
`timescale 1ns/100ps

module alu import alu_pkg::*; (
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  alu_op_e         op,
	output logic [XLEN-1:0] result,
	output logic            zero                  // High when result is zero
);

	logic [4:0] shamt;

	assign shamt = b[4:0];                         // RV32I shifts use the low 5 bits only
	assign zero  = (result == '0);

	always_comb begin
		case (op)
			ADD:               result = a + b;
			SUB:               result = a - b;       // Wraps on underflow
			AND:               result = a & b;
			OR:                result = a | b;
			XOR:               result = a ^ b;
			U_LOWER:           result = {{(XLEN-1){1'b0}}, (a < b)};
			S_LOWER:           result = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
			SHIFT_LEFT:        result = a << shamt;
			SHIFT_RIGHT_LOGIC: result = a >> shamt;
			SHIFT_RIGHT_ARIT:  result = $unsigned($signed(a) >>> shamt);  // Sign fill
			default:           result = '0;         // Unknown code gives zero
		endcase
	end

endmodule

/* verilog/alu_pkg.sv */
package alu_pkg;

	localparam int XLEN = 32;                   // Datapath width fixed by RV32I

	// Encodings follow the ALU operation table of the core.
	// Codes for the compare variants that only branches would need stay unused
	typedef enum logic [3:0] {
		ADD               = 4'b0000,              // a + b
		SUB               = 4'b0001,              // a - b
		AND               = 4'b0010,              // Bitwise and
		OR                = 4'b0011,              // Bitwise or
		XOR               = 4'b0100,              // Bitwise xor
		U_LOWER           = 4'b1001,              // a < b unsigned
		S_LOWER           = 4'b1010,              // a < b signed
		SHIFT_LEFT        = 4'b1101,              // a << b[4:0]
		SHIFT_RIGHT_LOGIC = 4'b1110,              // a >> b[4:0] with zero fill
		SHIFT_RIGHT_ARIT  = 4'b1111               // a >>> b[4:0] with sign fill
	} alu_op_e;

endpackage

/* verilog/exec_pipe.sv */
`timescale 1ns/100ps

module exec_pipe import alu_pkg::*, rv_isa_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            instr_valid,
	input  logic [31:0]     instr,
	output logic            wb_valid,
	output logic            wb_illegal,
	output reg_idx_t        wb_rd,
	output logic [XLEN-1:0] wb_data,
	output logic            wb_zero
);

	logic            s1_valid;                    // Decode to operand fetch
	logic            s1_illegal;
	reg_idx_t        s1_rs1;
	reg_idx_t        s1_rs2;
	reg_idx_t        s1_rd;
	logic [XLEN-1:0] s1_imm;
	logic            s1_use_imm;
	alu_op_e         s1_op;
	reg_idx_t        rd_addr_a;                   // Register file reads
	reg_idx_t        rd_addr_b;
	logic [XLEN-1:0] rd_data_a;
	logic [XLEN-1:0] rd_data_b;
	logic            s2_valid;                    // Operand fetch to execute
	logic            s2_illegal;
	reg_idx_t        s2_rd;
	alu_op_e         s2_op;
	logic [XLEN-1:0] s2_a;
	logic [XLEN-1:0] s2_b;
	logic            ex_valid;                    // Execute bypass path
	reg_idx_t        ex_rd;
	logic [XLEN-1:0] ex_result;

	instr_decoder instr_decoder_inst (
		.clk, .rst_n, .instr_valid, .instr,
		.s1_valid, .s1_illegal, .s1_rs1, .s1_rs2, .s1_rd, .s1_imm, .s1_use_imm, .s1_op
	);

	operand_stage operand_stage_inst (
		.clk, .rst_n,
		.s1_valid, .s1_illegal, .s1_rs1, .s1_rs2, .s1_rd, .s1_imm, .s1_use_imm, .s1_op,
		.rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b,
		.ex_valid, .ex_rd, .ex_result,
		.wb_valid, .wb_rd, .wb_data,
		.s2_valid, .s2_illegal, .s2_rd, .s2_op, .s2_a, .s2_b
	);

	execute_stage execute_stage_inst (
		.clk, .rst_n,
		.s2_valid, .s2_illegal, .s2_rd, .s2_op, .s2_a, .s2_b,
		.ex_valid, .ex_rd, .ex_result,
		.wb_valid, .wb_illegal, .wb_rd, .wb_data, .wb_zero
	);

	reg_file reg_file_inst (
		.clk, .rst_n,
		.we      (wb_valid),                        // Written one edge after writeback
		.wr_addr (wb_rd),
		.wr_data (wb_data),
		.rd_addr_a, .rd_addr_b, .rd_data_a, .rd_data_b
	);

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import alu_pkg::*, rv_isa_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            s2_valid,
	input  logic            s2_illegal,
	input  reg_idx_t        s2_rd,
	input  alu_op_e         s2_op,
	input  logic [XLEN-1:0] s2_a,
	input  logic [XLEN-1:0] s2_b,
	output logic            ex_valid,             // Bypass source for the operand stage
	output reg_idx_t        ex_rd,
	output logic [XLEN-1:0] ex_result,
	output logic            wb_valid,
	output logic            wb_illegal,
	output reg_idx_t        wb_rd,
	output logic [XLEN-1:0] wb_data,
	output logic            wb_zero
);

	logic [XLEN-1:0] alu_result;
	logic            alu_zero;

	alu alu_inst (
		.a      (s2_a),
		.b      (s2_b),
		.op     (s2_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	assign ex_valid  = s2_valid;                   // Illegal slots never forward
	assign ex_rd     = s2_rd;
	assign ex_result = alu_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid   <= 1'b0;
			wb_illegal <= 1'b0;
		end else begin
			wb_valid   <= s2_valid;                  // One-cycle pulse
			wb_illegal <= s2_illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (s2_valid) begin
			wb_rd   <= s2_rd;
			wb_data <= alu_result;
			wb_zero <= alu_zero;
		end
	end

endmodule

/* verilog/instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder import alu_pkg::*, rv_isa_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            instr_valid,          // One-cycle strobe for instr
	input  logic [31:0]     instr,
	output logic            s1_valid,
	output logic            s1_illegal,
	output reg_idx_t        s1_rs1,
	output reg_idx_t        s1_rs2,
	output reg_idx_t        s1_rd,
	output logic [XLEN-1:0] s1_imm,
	output logic            s1_use_imm,
	output alu_op_e         s1_op
);

	logic [6:0]      opcode;
	logic [2:0]      funct3;
	logic            alt;                         // Bit 30 picks SUB or SRA
	logic            funct7_rsvd;                 // Other funct7 bits must be clear
	logic            alt_ok;                      // Bit 30 has a meaning for this funct3
	logic            is_shift;
	logic            dec_legal;
	alu_op_e         dec_op;
	logic [XLEN-1:0] dec_imm;

	assign opcode      = instr[6:0];
	assign funct3      = instr[14:12];
	assign alt         = instr[30];
	assign funct7_rsvd = instr[31] | (|instr[29:25]);
	assign dec_imm     = {{(XLEN-12){instr[31]}}, instr[31:20]};  // Sign-extended I-immediate

	always_comb begin
		dec_op   = ADD;
		alt_ok   = 1'b0;
		is_shift = 1'b0;
		case (funct3)
			FUNCT3_ADD: begin
				alt_ok = (opcode == OP_REG);            // There is no SUBI
				if (alt && alt_ok)
					dec_op = SUB;
				else
					dec_op = ADD;
			end
			FUNCT3_SLL: begin
				dec_op   = SHIFT_LEFT;
				is_shift = 1'b1;
			end
			FUNCT3_SLT:  dec_op = S_LOWER;
			FUNCT3_SLTU: dec_op = U_LOWER;
			FUNCT3_XOR:  dec_op = XOR;
			FUNCT3_SR: begin
				alt_ok   = 1'b1;
				is_shift = 1'b1;
				if (alt)
					dec_op = SHIFT_RIGHT_ARIT;             // SRA and SRAI
				else
					dec_op = SHIFT_RIGHT_LOGIC;            // SRL and SRLI
			end
			FUNCT3_OR:   dec_op = OR;
			FUNCT3_AND:  dec_op = AND;
			default:     dec_op = ADD;
		endcase
	end

	always_comb begin
		case (opcode)
			OP_REG:  dec_legal = !funct7_rsvd && (alt_ok || !alt);
			OP_IMM: begin
				if (is_shift)
					dec_legal = !funct7_rsvd && (alt_ok || !alt);
				else
					dec_legal = funct7_rsvd || !alt;     // Bit 30 alone is the SUB-style pattern
			end
			default: dec_legal = 1'b0;                 // Any other opcode is illegal
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid   <= 1'b0;
			s1_illegal <= 1'b0;
		end else begin
			s1_valid   <= instr_valid && dec_legal;
			s1_illegal <= instr_valid && !dec_legal;   // Flag travels in place of valid
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin                       // Fields only move with a strobe
			s1_rs1     <= instr[19:15];
			s1_rs2     <= instr[24:20];
			s1_rd      <= instr[11:7];
			s1_imm     <= dec_imm;
			s1_use_imm <= (opcode == OP_IMM);
			s1_op      <= dec_op;
		end
	end

endmodule

/* verilog/operand_stage.sv */
`timescale 1ns/100ps

module operand_stage import alu_pkg::*, rv_isa_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            s1_valid,
	input  logic            s1_illegal,
	input  reg_idx_t        s1_rs1,
	input  reg_idx_t        s1_rs2,
	input  reg_idx_t        s1_rd,
	input  logic [XLEN-1:0] s1_imm,
	input  logic            s1_use_imm,
	input  alu_op_e         s1_op,
	output reg_idx_t        rd_addr_a,            // Register file read ports
	output reg_idx_t        rd_addr_b,
	input  logic [XLEN-1:0] rd_data_a,
	input  logic [XLEN-1:0] rd_data_b,
	input  logic            ex_valid,             // Instruction now in execute
	input  reg_idx_t        ex_rd,
	input  logic [XLEN-1:0] ex_result,
	input  logic            wb_valid,             // Instruction now in writeback
	input  reg_idx_t        wb_rd,
	input  logic [XLEN-1:0] wb_data,
	output logic            s2_valid,
	output logic            s2_illegal,
	output reg_idx_t        s2_rd,
	output alu_op_e         s2_op,
	output logic [XLEN-1:0] s2_a,
	output logic [XLEN-1:0] s2_b
);

	logic [XLEN-1:0] fwd_a;
	logic [XLEN-1:0] fwd_b;

	// Newest producer wins. x0 always reads zero
	function automatic logic [XLEN-1:0] bypass(
		input reg_idx_t        idx,
		input logic [XLEN-1:0] rf_val,
		input logic            e_valid,
		input reg_idx_t        e_rd,
		input logic [XLEN-1:0] e_data,
		input logic            w_valid,
		input reg_idx_t        w_rd,
		input logic [XLEN-1:0] w_data
	);
		if (idx == '0)
			return '0;
		if (e_valid && (e_rd == idx))
			return e_data;                             // Distance 1
		if (w_valid && (w_rd == idx))
			return w_data;                             // Distance 2
		return rf_val;                               // Distance 3 and up
	endfunction

	assign rd_addr_a = s1_rs1;
	assign rd_addr_b = s1_rs2;

	always_comb begin
		fwd_a = bypass(s1_rs1, rd_data_a, ex_valid, ex_rd, ex_result, wb_valid, wb_rd, wb_data);
		fwd_b = bypass(s1_rs2, rd_data_b, ex_valid, ex_rd, ex_result, wb_valid, wb_rd, wb_data);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s2_valid   <= 1'b0;
			s2_illegal <= 1'b0;
		end else begin
			s2_valid   <= s1_valid;
			s2_illegal <= s1_illegal;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid) begin
			s2_rd <= s1_rd;
			s2_op <= s1_op;
			s2_a  <= fwd_a;
			s2_b  <= s1_use_imm ? s1_imm : fwd_b;      // OP-IMM takes the immediate
		end
	end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/100ps

module reg_file import alu_pkg::*, rv_isa_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            we,                   // Write strobe from writeback
	input  reg_idx_t        wr_addr,
	input  logic [XLEN-1:0] wr_data,
	input  reg_idx_t        rd_addr_a,
	input  reg_idx_t        rd_addr_b,
	output logic [XLEN-1:0] rd_data_a,
	output logic [XLEN-1:0] rd_data_b
);

	localparam int REG_COUNT = 2 ** $bits(reg_idx_t);  // 32 architectural registers

	logic [XLEN-1:0] regs [REG_COUNT];
	logic            wr_live;                     // A real write is happening this cycle

	assign wr_live = we && (wr_addr != '0);        // x0 is never stored

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;                          // Whole file comes up as zero
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Asynchronous reads. x0 first, then the write in flight, then storage
	assign rd_data_a = (rd_addr_a == '0) ? '0 :
		(wr_live && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 :
		(wr_live && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

	// Major opcodes handled by the execute path
	typedef enum logic [6:0] {
		OP_REG = 7'b0110011,                      // Register-register ALU group
		OP_IMM = 7'b0010011                       // Register-immediate ALU group
	} opcode_e;

	// funct3 field codes shared by OP and OP-IMM
	localparam logic [2:0] FUNCT3_ADD  = 3'b000;  // ADD, SUB, ADDI
	localparam logic [2:0] FUNCT3_SLL  = 3'b001;  // SLL, SLLI
	localparam logic [2:0] FUNCT3_SLT  = 3'b010;  // SLT, SLTI
	localparam logic [2:0] FUNCT3_SLTU = 3'b011;  // SLTU, SLTIU
	localparam logic [2:0] FUNCT3_XOR  = 3'b100;  // XOR, XORI
	localparam logic [2:0] FUNCT3_SR   = 3'b101;  // SRL, SRA and the immediate forms
	localparam logic [2:0] FUNCT3_OR   = 3'b110;  // OR, ORI
	localparam logic [2:0] FUNCT3_AND  = 3'b111;  // AND, ANDI

	typedef logic [4:0] reg_idx_t;              // Index into the 32-entry register file

endpackage
